/* sim.f */
pipePkg.sv
instQueue.sv
regFile.sv
decodeStage.sv
executeStage.sv
resultStage.sv
coreTop.sv
coreTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= coreTb
FILE_LIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILE_LIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Some tests failed" $(LOG); then exit 1; fi; \
	exit $$status

lint:
	$(VERILATOR) --lint-only --timing -f $(FILE_LIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* coreTb.sv */
`timescale 1ns/1ps

module coreTb;

	localparam int QUEUE_DEPTH = 4;
	localparam int DMEM_WORDS = 64;
	localparam int RESET_CYCLES = 16;
	localparam int DRAIN_CYCLES = 8;

	logic CLK;
	logic RST;
	logic i_instValid;
	pipePkg::instWord_u i_inst;
	logic o_creditReturn;
	pipePkg::wb_t o_wb;

	// program and the writes it should produce, in order
	pipePkg::instWord_u instTab[$];
	logic [pipePkg::REG_BITS-1:0] expReg[$];
	logic [pipePkg::XLEN-1:0] expVal[$];

	integer seed;
	int errors;
	int credits;
	int sentCount;
	int gotWrites;
	int returnCount;
	int cycles;
	int cycleLimit;
	int edgeCount;
	logic timedOut;
	logic finished;

	coreTop #(
		.QUEUE_DEPTH(QUEUE_DEPTH),
		.DMEM_WORDS(DMEM_WORDS)
	) uut (
		.CLK(CLK),
		.RST(RST),
		.i_instValid(i_instValid),
		.i_inst(i_inst),
		.o_creditReturn(o_creditReturn),
		.o_wb(o_wb)
	);

	always #50 CLK = ~CLK;

	////////////////////////////////////////
	// instruction encoders
	////////////////////////////////////////

	function automatic pipePkg::instWord_u rType(
		input logic [5:0] funct,
		input logic [4:0] rd,
		input logic [4:0] rs,
		input logic [4:0] rt
	);
		pipePkg::instWord_u w;
		w.r.op = pipePkg::OP_RTYPE;
		w.r.rs = rs;
		w.r.rt = rt;
		w.r.rd = rd;
		w.r.shamt = '0;
		w.r.funct = funct;
		return w;
	endfunction

	function automatic pipePkg::instWord_u iType(
		input logic [5:0] op,
		input logic [4:0] rt,
		input logic [4:0] rs,
		input logic [15:0] imm
	);
		pipePkg::instWord_u w;
		w.i.op = op;
		w.i.rs = rs;
		w.i.rt = rt;
		w.i.imm = imm;
		return w;
	endfunction

	task automatic addEntry(
		input pipePkg::instWord_u inst,
		input logic writes,
		input logic [4:0] dest,
		input logic [31:0] val
	);
		instTab.push_back(inst);
		if (writes)
		begin
			expReg.push_back(dest);
			expVal.push_back(val);
		end
	endtask

	task automatic buildTable;
		addEntry(iType(pipePkg::OP_ADDI, 5'd1, 5'd0, 16'd5), 1, 5'd1, 32'd5);
		addEntry(iType(pipePkg::OP_ADDI, 5'd2, 5'd0, 16'hFFFD), 1, 5'd2, 32'hFFFF_FFFD);
		addEntry(rType(pipePkg::FN_ADD, 5'd3, 5'd1, 5'd2), 1, 5'd3, 32'd2);
		addEntry(rType(pipePkg::FN_SUB, 5'd4, 5'd1, 5'd2), 1, 5'd4, 32'd8);
		addEntry(rType(pipePkg::FN_AND, 5'd5, 5'd1, 5'd2), 1, 5'd5, 32'd5);
		addEntry(rType(pipePkg::FN_OR, 5'd6, 5'd1, 5'd2), 1, 5'd6, 32'hFFFF_FFFD);
		addEntry(iType(pipePkg::OP_ADDI, 5'd7, 5'd3, 16'd100), 1, 5'd7, 32'd102);
		addEntry(rType(pipePkg::FN_ADD, 5'd8, 5'd7, 5'd7), 1, 5'd8, 32'd204); // back to back
		addEntry(rType(pipePkg::FN_SUB, 5'd9, 5'd8, 5'd1), 1, 5'd9, 32'd199);
		addEntry(iType(pipePkg::OP_SW, 5'd9, 5'd0, 16'd8), 0, 5'd0, 32'd0); // word 2
		addEntry(iType(pipePkg::OP_LW, 5'd10, 5'd0, 16'd8), 1, 5'd10, 32'd199);
		addEntry(rType(pipePkg::FN_ADD, 5'd11, 5'd10, 5'd1), 1, 5'd11, 32'd204); // load use
		addEntry(iType(pipePkg::OP_ADDI, 5'd0, 5'd1, 16'd7), 0, 5'd0, 32'd0); // r0 target
		addEntry(rType(pipePkg::FN_ADD, 5'd12, 5'd0, 5'd1), 1, 5'd12, 32'd5);
		addEntry(iType(pipePkg::OP_SW, 5'd6, 5'd0, 16'd16), 0, 5'd0, 32'd0);
		addEntry(iType(pipePkg::OP_LW, 5'd13, 5'd0, 16'd16), 1, 5'd13, 32'hFFFF_FFFD);
		addEntry(rType(pipePkg::FN_AND, 5'd14, 5'd13, 5'd8), 1, 5'd14, 32'd204);
		addEntry(rType(pipePkg::FN_SUB, 5'd15, 5'd1, 5'd8), 1, 5'd15, 32'hFFFF_FF39);
		addEntry(iType(6'b111111, 5'd20, 5'd1, 16'd0), 0, 5'd0, 32'd0); // unknown op as bubble
		addEntry(rType(pipePkg::FN_OR, 5'd16, 5'd15, 5'd12), 1, 5'd16, 32'hFFFF_FF3D);
		addEntry(iType(pipePkg::OP_ADDI, 5'd1, 5'd1, 16'hFFFF), 1, 5'd1, 32'd4);
		addEntry(rType(pipePkg::FN_ADD, 5'd17, 5'd1, 5'd1), 1, 5'd17, 32'd8);
	endtask

	////////////////////////////////////////
	// result monitor
	////////////////////////////////////////

	always @(negedge CLK)
	begin
		if (edgeCount < RESET_CYCLES + 1) // reset and the first edge after it
		begin
			assert (!o_wb.valid && !o_creditReturn)
			else
			begin
				errors++;
				$display("CHECK FAILED at %0t: output active around reset", $time);
			end
			edgeCount++;
		end
		if (o_creditReturn)
			returnCount++;
		if (o_wb.valid)
		begin
			assert (gotWrites < expReg.size())
			else
			begin
				errors++;
				$display("unexpected extra register write to r%0d at %0t",
					o_wb.destReg, $time);
			end
			if (gotWrites < expReg.size())
			begin
				assert ((o_wb.destReg == expReg[gotWrites]) && (o_wb.data == expVal[gotWrites]))
				else
				begin
					errors++;
					$display("CHECK FAILED at %0t: write %0d gave r%0d=%h, expected r%0d=%h",
						$time, gotWrites, o_wb.destReg, o_wb.data,
						expReg[gotWrites], expVal[gotWrites]);
				end
			end
			gotWrites++;
		end
	end

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		CLK = 1'b0;
		RST = 1'b1;
		i_instValid = 1'b0;
		i_inst = '0;
		seed = 32'h2d76fcb3;
		errors = 0;
		gotWrites = 0;
		returnCount = 0;
		edgeCount = 0;
		buildTable();
		cycleLimit = instTab.size() * 8 + 100;

		repeat (RESET_CYCLES) @(posedge CLK);
		@(negedge CLK);
		RST = 1'b0;

		credits = QUEUE_DEPTH;
		sentCount = 0;
		cycles = 0;
		timedOut = 1'b0;
		finished = 1'b0;
		while (!finished && !timedOut)
		begin
			if (o_creditReturn)
				credits++;
			assert (credits <= QUEUE_DEPTH)
			else
			begin
				errors++;
				$display("more credits returned than the queue holds at %0t", $time);
			end
			// send only with a credit in hand
			if ((sentCount < instTab.size()) && (credits > 0) && (($random(seed) & 3) != 0))
			begin
				i_instValid = 1'b1;
				i_inst = instTab[sentCount];
				sentCount++;
				credits--;
			end
			else
			begin
				i_instValid = 1'b0; // random idle gap
				i_inst = '0;
			end
			@(negedge CLK);
			cycles++;
			if (cycles >= cycleLimit)
				timedOut = 1'b1;
			finished = (sentCount == instTab.size()) && (gotWrites >= expReg.size());
		end
		i_instValid = 1'b0;
		i_inst = '0;

		if (timedOut)
		begin
			errors++;
			$display("timeout: results did not finish within %0d cycles", cycleLimit);
		end

		repeat (DRAIN_CYCLES) @(negedge CLK); // catch late or extra writes

		assert (returnCount == sentCount)
		else
		begin
			errors++;
			$display("credit returns %0d do not match %0d instructions sent",
				returnCount, sentCount);
		end

		$display("errors: %0d, writes: %0d of %0d, credit returns: %0d of %0d",
			errors, gotWrites, expReg.size(), returnCount, instTab.size());
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

/* coreTop.sv */
`timescale 1ns/1ps

module coreTop #(
	parameter int QUEUE_DEPTH = 4,
	parameter int DMEM_WORDS = 64
) (
	input logic CLK,
	input logic RST,
	input logic i_instValid,
	input pipePkg::instWord_u i_inst,
	output logic o_creditReturn,
	output pipePkg::wb_t o_wb
);

	logic headValid;
	pipePkg::instWord_u head;
	logic pop;
	pipePkg::idEx_t idEx;
	pipePkg::exMem_t exMem;

	instQueue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) queue (
		.CLK(CLK),
		.RST(RST),
		.i_instValid(i_instValid),
		.i_inst(i_inst),
		.i_pop(pop),
		.o_headValid(headValid),
		.o_head(head),
		.o_creditReturn(o_creditReturn)
	);

	decodeStage decode (
		.CLK(CLK),
		.RST(RST),
		.i_headValid(headValid),
		.i_head(head),
		.i_exMem(exMem), // interlock view of the memory stage
		.i_wb(o_wb),
		.o_pop(pop),
		.o_idEx(idEx)
	);

	executeStage execute (
		.CLK(CLK),
		.RST(RST),
		.i_idEx(idEx),
		.o_exMem(exMem)
	);

	resultStage #(
		.DMEM_WORDS(DMEM_WORDS)
	) result (
		.CLK(CLK),
		.RST(RST),
		.i_exMem(exMem),
		.o_wb(o_wb)
	);

endmodule

/* resultStage.sv */
`timescale 1ns/1ps

module resultStage #(
	parameter int DMEM_WORDS = 64
) (
	input logic CLK,
	input logic RST,
	input pipePkg::exMem_t i_exMem,
	output pipePkg::wb_t o_wb
);

	localparam int ADDR_BITS = (DMEM_WORDS > 1) ? $clog2(DMEM_WORDS) : 1;

	logic [pipePkg::XLEN-1:0] dmem [DMEM_WORDS];
	logic [ADDR_BITS-1:0] wordIdx;
	logic [pipePkg::XLEN-1:0] loadData;
	logic storeEn;

	assign wordIdx = i_exMem.aluResult[ADDR_BITS+1:2]; // drop byte offset
	assign loadData = dmem[wordIdx];
	assign storeEn = i_exMem.valid && i_exMem.ctrl.memWrite;

	////////////////////////////////////////
	// data memory
	////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		if (RST)
		begin
			for (int k = 0; k < DMEM_WORDS; k++)
				dmem[k] <= '0;
		end
		else if (storeEn)
			dmem[wordIdx] <= i_exMem.storeData;
	end

	// writeback register driving the core's result port
	always_ff @(posedge CLK)
	begin
		o_wb.destReg <= i_exMem.destReg;
		o_wb.data <= i_exMem.ctrl.memToReg ? loadData : i_exMem.aluResult;
		if (RST)
			o_wb.valid <= 1'b0;
		else
			o_wb.valid <= i_exMem.valid && i_exMem.ctrl.regWrite
				&& (i_exMem.destReg != '0);
	end

	// lw/sw address must land inside the memory
	assert property (@(posedge CLK) disable iff (RST)
		(i_exMem.valid && (i_exMem.ctrl.memRead || i_exMem.ctrl.memWrite))
		|-> (i_exMem.aluResult[pipePkg::XLEN-1:2] < DMEM_WORDS));

endmodule

/* executeStage.sv */
`timescale 1ns/1ps

module executeStage (
	input logic CLK,
	input logic RST,
	input pipePkg::idEx_t i_idEx,
	output pipePkg::exMem_t o_exMem
);

	pipePkg::aluOp_e aluOp;
	logic [pipePkg::XLEN-1:0] operandB;
	logic [pipePkg::XLEN-1:0] aluResult;

	// ALU control
	always_comb
	begin
		aluOp = pipePkg::ALU_ADD; // addi, lw, sw address
		if (i_idEx.ctrl.aluSel)
		begin
			case (i_idEx.funct)
				pipePkg::FN_SUB: aluOp = pipePkg::ALU_SUB;
				pipePkg::FN_AND: aluOp = pipePkg::ALU_AND;
				pipePkg::FN_OR: aluOp = pipePkg::ALU_OR;
				default: aluOp = pipePkg::ALU_ADD;
			endcase
		end
	end

	assign operandB = i_idEx.ctrl.aluSrc ? i_idEx.signExtImm : i_idEx.rtData;

	always_comb
	begin
		case (aluOp)
			pipePkg::ALU_AND: aluResult = i_idEx.rsData & operandB;
			pipePkg::ALU_OR: aluResult = i_idEx.rsData | operandB;
			pipePkg::ALU_ADD: aluResult = i_idEx.rsData + operandB;
			pipePkg::ALU_SUB: aluResult = i_idEx.rsData - operandB;
		endcase
	end

	////////////////////////////////////////
	// execute to memory register
	////////////////////////////////////////

	always_ff @(posedge CLK)
	begin
		o_exMem.aluResult <= aluResult;
		o_exMem.storeData <= i_idEx.rtData; // sw source
		o_exMem.destReg <= i_idEx.destReg;
		if (RST)
		begin
			o_exMem.valid <= 1'b0;
			o_exMem.ctrl <= '0;
		end
		else
		begin
			o_exMem.valid <= i_idEx.valid;
			o_exMem.ctrl <= i_idEx.ctrl;
		end
	end

endmodule

/* decodeStage.sv */
`timescale 1ns/1ps

module decodeStage (
	input logic CLK,
	input logic RST,
	input logic i_headValid,
	input pipePkg::instWord_u i_head,
	input pipePkg::exMem_t i_exMem,
	input pipePkg::wb_t i_wb,
	output logic o_pop,
	output pipePkg::idEx_t o_idEx
);

	pipePkg::ctrl_t decCtrl;
	logic [pipePkg::XLEN-1:0] rsData;
	logic [pipePkg::XLEN-1:0] rtData;
	logic [pipePkg::XLEN-1:0] signExtImm;
	logic [pipePkg::REG_BITS-1:0] destReg;
	logic useRt;
	logic stall;

	regFile regs (
		.CLK(CLK),
		.RST(RST),
		.i_rsIdx(i_head.r.rs),
		.i_rtIdx(i_head.r.rt),
		.i_wb(i_wb),
		.o_rsData(rsData),
		.o_rtData(rtData)
	);

	////////////////////////////////////////
	// control decode
	////////////////////////////////////////

	always_comb
	begin
		decCtrl = '0; // unknown opcode flows as a no-op
		case (i_head.r.op)
			pipePkg::OP_RTYPE:
			begin
				decCtrl.regWrite = 1'b1;
				decCtrl.aluSel = 1'b1;
			end
			pipePkg::OP_ADDI:
			begin
				decCtrl.regWrite = 1'b1;
				decCtrl.aluSrc = 1'b1;
			end
			pipePkg::OP_LW:
			begin
				decCtrl.regWrite = 1'b1;
				decCtrl.memRead = 1'b1;
				decCtrl.memToReg = 1'b1;
				decCtrl.aluSrc = 1'b1;
			end
			pipePkg::OP_SW:
			begin
				decCtrl.memWrite = 1'b1;
				decCtrl.aluSrc = 1'b1;
			end
			default: ;
		endcase
	end

	assign useRt = (i_head.r.op == pipePkg::OP_RTYPE) || (i_head.r.op == pipePkg::OP_SW);
	assign destReg = (i_head.r.op == pipePkg::OP_RTYPE) ? i_head.r.rd : i_head.r.rt;
	assign signExtImm = {{(pipePkg::XLEN - 16){i_head.i.imm[15]}}, i_head.i.imm};

	////////////////////////////////////////
	// interlock
	////////////////////////////////////////

	// true when src is still owed by an older writer in flight
	function automatic logic pending(
		input logic [pipePkg::REG_BITS-1:0] src,
		input logic valid,
		input logic regWrite,
		input logic [pipePkg::REG_BITS-1:0] dest
	);
		return valid && regWrite && (src != '0) && (src == dest);
	endfunction

	always_comb
	begin
		stall = pending(i_head.r.rs, o_idEx.valid, o_idEx.ctrl.regWrite, o_idEx.destReg)
			|| pending(i_head.r.rs, i_exMem.valid, i_exMem.ctrl.regWrite, i_exMem.destReg);
		if (useRt)
			stall = stall
				|| pending(i_head.r.rt, o_idEx.valid, o_idEx.ctrl.regWrite, o_idEx.destReg)
				|| pending(i_head.r.rt, i_exMem.valid, i_exMem.ctrl.regWrite, i_exMem.destReg);
	end

	assign o_pop = i_headValid && !stall;

	// decode to execute register
	always_ff @(posedge CLK)
	begin
		o_idEx.rsData <= rsData;
		o_idEx.rtData <= rtData;
		o_idEx.signExtImm <= signExtImm;
		o_idEx.funct <= i_head.r.funct;
		o_idEx.destReg <= destReg;
		if (RST)
		begin
			o_idEx.valid <= 1'b0;
			o_idEx.ctrl <= '0;
		end
		else
		begin
			o_idEx.valid <= o_pop; // bubble when nothing issues
			o_idEx.ctrl <= o_pop ? decCtrl : '0;
		end
	end

	// a held head stays in place until it issues
	assert property (@(posedge CLK) disable iff (RST)
		(i_headValid && !o_pop) |=> (i_headValid && (i_head == $past(i_head))));

endmodule

/* regFile.sv */
`timescale 1ns/1ps

module regFile (
	input logic CLK,
	input logic RST,
	input logic [pipePkg::REG_BITS-1:0] i_rsIdx,
	input logic [pipePkg::REG_BITS-1:0] i_rtIdx,
	input pipePkg::wb_t i_wb,
	output logic [pipePkg::XLEN-1:0] o_rsData,
	output logic [pipePkg::XLEN-1:0] o_rtData
);

	logic [pipePkg::XLEN-1:0] regs [1:31]; // r0 is not stored

	// read with bypass of the write landing this edge
	function automatic logic [pipePkg::XLEN-1:0] readPort(
		input logic [pipePkg::REG_BITS-1:0] idx
	);
		logic [pipePkg::XLEN-1:0] val;
		if (idx == '0)
			val = '0;
		else if (i_wb.valid && (i_wb.destReg == idx))
			val = i_wb.data;
		else
			val = regs[idx];
		return val;
	endfunction

	always_comb
	begin
		o_rsData = readPort(i_rsIdx);
		o_rtData = readPort(i_rtIdx);
	end

	always_ff @(posedge CLK)
	begin
		if (RST)
		begin
			for (int k = 1; k < 32; k++)
				regs[k] <= '0;
		end
		else if (i_wb.valid && (i_wb.destReg != '0))
			regs[i_wb.destReg] <= i_wb.data;
	end

endmodule

/* instQueue.sv */
`timescale 1ns/1ps

module instQueue #(
	parameter int QUEUE_DEPTH = 4
) (
	input logic CLK,
	input logic RST,
	input logic i_instValid,
	input pipePkg::instWord_u i_inst,
	input logic i_pop,
	output logic o_headValid,
	output pipePkg::instWord_u o_head,
	output logic o_creditReturn
);

	localparam int PTR_BITS = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
	localparam int CNT_BITS = $clog2(QUEUE_DEPTH + 1);

	pipePkg::instWord_u storage [QUEUE_DEPTH];
	logic [PTR_BITS-1:0] wrPtr;
	logic [PTR_BITS-1:0] rdPtr;
	logic [CNT_BITS-1:0] count;
	logic doPop;

	assign doPop = i_pop && o_headValid;
	assign o_headValid = (count != '0);
	assign o_head = storage[rdPtr];

	// circular buffer slots
	always_ff @(posedge CLK)
	begin
		if (i_instValid)
			storage[wrPtr] <= i_inst;
	end

	always_ff @(posedge CLK)
	begin
		if (RST)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
			o_creditReturn <= 1'b0;
		end
		else
		begin
			if (i_instValid)
				wrPtr <= (wrPtr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
			if (doPop)
				rdPtr <= (rdPtr == PTR_BITS'(QUEUE_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
			count <= count + CNT_BITS'(i_instValid) - CNT_BITS'(doPop);
			o_creditReturn <= doPop; // one credit back per issued slot
		end
	end

	// sender must hold a credit for every write
	assert property (@(posedge CLK) disable iff (RST)
		i_instValid |-> (count != CNT_BITS'(QUEUE_DEPTH)));

	// decode only pops a waiting head
	assert property (@(posedge CLK) disable iff (RST)
		i_pop |-> (count != '0));

endmodule

/* pipePkg.sv */
package pipePkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int XLEN = 32;
	localparam int REG_BITS = 5;

	// opcode field values
	localparam logic [5:0] OP_RTYPE = 6'b000000;
	localparam logic [5:0] OP_ADDI = 6'b001000;
	localparam logic [5:0] OP_LW = 6'b100011;
	localparam logic [5:0] OP_SW = 6'b101011;

	// R-format funct values
	localparam logic [5:0] FN_ADD = 6'b100000;
	localparam logic [5:0] FN_SUB = 6'b100010;
	localparam logic [5:0] FN_AND = 6'b100100;
	localparam logic [5:0] FN_OR = 6'b100101;

	////////////////////////////////////////
	// instruction word
	////////////////////////////////////////

	typedef struct packed {
		logic [5:0] op;
		logic [REG_BITS-1:0] rs;
		logic [REG_BITS-1:0] rt;
		logic [REG_BITS-1:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} rFmt_t;

	typedef struct packed {
		logic [5:0] op;
		logic [REG_BITS-1:0] rs;
		logic [REG_BITS-1:0] rt;
		logic [15:0] imm;
	} iFmt_t;

	// same 32 bits, read as R or I format
	typedef union packed {
		rFmt_t r;
		iFmt_t i;
	} instWord_u;

	typedef enum logic [1:0] {
		ALU_AND,
		ALU_OR,
		ALU_ADD,
		ALU_SUB
	} aluOp_e;

	////////////////////////////////////////
	// stage records
	////////////////////////////////////////

	typedef struct packed {
		logic regWrite;
		logic memRead;
		logic memWrite;
		logic memToReg;
		logic aluSrc; // immediate as second operand
		logic aluSel; // 1 = take op from funct, 0 = plain add
	} ctrl_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		logic [XLEN-1:0] rsData;
		logic [XLEN-1:0] rtData;
		logic [XLEN-1:0] signExtImm;
		logic [5:0] funct;
		logic [REG_BITS-1:0] destReg;
	} idEx_t;

	typedef struct packed {
		logic valid;
		ctrl_t ctrl;
		logic [XLEN-1:0] aluResult;
		logic [XLEN-1:0] storeData;
		logic [REG_BITS-1:0] destReg;
	} exMem_t;

	typedef struct packed {
		logic valid;
		logic [REG_BITS-1:0] destReg;
		logic [XLEN-1:0] data;
	} wb_t;

endpackage
